//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = pipe5_tb
FILELIST = pipe5.f
LOG      = sim.log
OBJ      = obj_dir

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ)/V$(TOP) | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "Regression passed" $(LOG) || (echo "Simulation ended early"; exit 1)

clean:
	rm -rf $(OBJ) $(LOG)

//--- pipe5.f
verilog/pipe5_pkg.sv
verilog/alu.sv
verilog/regfile.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/mem_wb_stage.sv
verilog/pipe5_cpu.sv
test/pipe5_assertions.sv
test/pipe5_tb.sv

//--- test/pipe5_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module pipe5_assertions import pipe5_pkg::*; (
    input logic   clock,
    input logic   rst_n,
    input logic   wren,
    input logic   wb_en,
    input instr_t mw_instr,
    input instr_t dx_instr
);

    // Back end quiet in the cycle after a reset edge
    quiet_after_reset: assert property (@(posedge clock) !rst_n |=> (!wren && !wb_en))
        else $error("wren or wb_en high right after reset");

    // Register writes come only from jal or from a writer with a real rd
    no_r0_write: assert property (@(posedge clock) disable iff (!rst_n)
        wb_en |-> (mw_instr.r.opcode == op_jal
                   || ((mw_instr.r.opcode == op_rtype || mw_instr.r.opcode == op_addi
                        || mw_instr.r.opcode == op_lw) && mw_instr.r.rd != reg_zero)))
        else $error("register file write from a non-writer or to r0");

    // Store enable traces back to an sw that left execute one cycle earlier
    wren_only_sw: assert property (@(posedge clock) disable iff (!rst_n)
        wren |-> ($past(dx_instr.i.opcode) == op_sw))
        else $error("wren high for an instruction other than sw");

endmodule

bind mem_wb_stage pipe5_assertions i_pipe5_assertions (
    .clock    (clock),
    .rst_n    (rst_n),
    .wren     (wren),
    .wb_en    (wb_en),
    .mw_instr (mw_instr),
    .dx_instr (dx_instr)
);

`default_nettype wire

//--- test/pipe5_tb.sv
`timescale 1ns/1ns
`default_nettype none

module pipe5_tb import pipe5_pkg::*; ();

    localparam int num_tests = 6;
    localparam int max_prog  = 24;
    localparam int max_st    = 8;
    localparam int max_data  = 2;
    localparam int end_addr  = 1023;    // Final store marks program end

    logic            clock = 1'b0;
    logic            rst_n = 1'b0;
    logic [11:0]     address_imem;
    instr_t          q_imem;
    logic [xlen-1:0] address_dmem;
    logic [xlen-1:0] data;
    logic            wren;
    logic [xlen-1:0] q_dmem;

    logic [31:0]     imem [4096];
    logic [xlen-1:0] dmem [1024];

    // Test table: program, preloaded data, expected stores in order
    logic [31:0]     prog     [num_tests][max_prog];
    int              prog_len [num_tests];
    int              data_addr [num_tests][max_data];
    logic [xlen-1:0] data_val  [num_tests][max_data];
    int              data_cnt  [num_tests];
    logic [xlen-1:0] exp_addr [num_tests][max_st];
    logic [xlen-1:0] exp_data [num_tests][max_st];
    int              exp_cnt  [num_tests];

    integer seed = 37;
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;
    int     cycle_limit = 0;    // Set once the table is built
    int     total_len;

    always #4 clock = ~clock;    // 8 ns period

    pipe5_cpu #(.pc_w(12)) i_pipe5_cpu (
        .clock        (clock),
        .rst_n        (rst_n),
        .address_imem (address_imem),
        .q_imem       (q_imem),
        .address_dmem (address_dmem),
        .data         (data),
        .wren         (wren),
        .q_dmem       (q_dmem)
    );

    // Both memories answer in the same cycle
    assign q_imem = imem[address_imem];
    assign q_dmem = dmem[address_dmem[9:0]];

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: no end store after %0d cycles", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    function automatic logic [31:0] rtype_word(input logic [4:0] alu, input int rd,
                                               input int rs, input int rt, input int shamt);
        return {op_rtype, rd[4:0], rs[4:0], rt[4:0], shamt[4:0], alu, 2'b00};
    endfunction

    function automatic logic [31:0] itype_word(input logic [4:0] op, input int rd,
                                               input int rs, input int imm);
        return {op, rd[4:0], rs[4:0], imm[16:0]};    // imm is signed
    endfunction

    function automatic logic [31:0] jump_word(input logic [4:0] op, input int target);
        return {op, target[26:0]};
    endfunction

    task automatic append_instr(input int t, input logic [31:0] word);
        prog[t][prog_len[t]] = word;
        prog_len[t]++;
    endtask

    task automatic preload_word(input int t, input int addr, input logic [xlen-1:0] value);
        data_addr[t][data_cnt[t]] = addr;
        data_val[t][data_cnt[t]]  = value;
        data_cnt[t]++;
    endtask

    task automatic expect_store(input int t, input logic [xlen-1:0] addr,
                                input logic [xlen-1:0] value);
        exp_addr[t][exp_cnt[t]] = addr;
        exp_data[t][exp_cnt[t]] = value;
        exp_cnt[t]++;
    endtask

    // End store, then spin in place
    task automatic close_program(input int t);
        int pos;
        pos = prog_len[t];
        append_instr(t, itype_word(op_sw, 0, 0, end_addr));
        append_instr(t, jump_word(op_j, pos + 1));
    endtask

    task automatic build_table();
        logic [xlen-1:0] d0;
        logic [xlen-1:0] d1;
        logic [xlen-1:0] r3;
        logic [xlen-1:0] r4;
        logic [xlen-1:0] r5;
        logic [xlen-1:0] r6;
        logic [xlen-1:0] r7;
        logic [xlen-1:0] r8;
        logic [xlen-1:0] r10;
        for (int t = 0; t < num_tests; t++) begin
            prog_len[t] = 0;
            data_cnt[t] = 0;
            exp_cnt[t]  = 0;
        end
        // Dependent ALU chain on random words, MX and WX paths
        d0  = $random(seed);
        d1  = $random(seed);
        r3  = d0 + d1;
        r4  = r3 - 32'd5;
        r5  = r4 & r3;
        r6  = r5 | d0;
        r7  = r6 << 3;
        r8  = $signed(r7) >>> 5;
        r10 = r8 - 32'd7;
        append_instr(0, itype_word(op_lw, 1, 0, 0));
        append_instr(0, itype_word(op_lw, 2, 0, 1));
        append_instr(0, itype_word(op_addi, 9, 0, 5));
        append_instr(0, rtype_word(alu_add, 3, 1, 2, 0));
        append_instr(0, rtype_word(alu_sub, 4, 3, 9, 0));
        append_instr(0, rtype_word(alu_and, 5, 4, 3, 0));
        append_instr(0, rtype_word(alu_or, 6, 5, 1, 0));
        append_instr(0, rtype_word(alu_sll, 7, 6, 0, 3));
        append_instr(0, rtype_word(alu_sra, 8, 7, 0, 5));
        append_instr(0, itype_word(op_addi, 10, 8, -7));
        append_instr(0, itype_word(op_sw, 10, 0, 8));      // Store data straight from MX
        for (int r = 3; r <= 8; r++) begin
            append_instr(0, itype_word(op_sw, r, 0, r - 1));
        end
        close_program(0);
        preload_word(0, 0, d0);
        preload_word(0, 1, d1);
        expect_store(0, 8, r10);
        expect_store(0, 2, r3);
        expect_store(0, 3, r4);
        expect_store(0, 4, r5);
        expect_store(0, 5, r6);
        expect_store(0, 6, r7);
        expect_store(0, 7, r8);
        // Load-use on rs, then on rt
        append_instr(1, itype_word(op_addi, 1, 0, 100));
        append_instr(1, itype_word(op_lw, 2, 1, 3));
        append_instr(1, rtype_word(alu_add, 3, 2, 1, 0));
        append_instr(1, itype_word(op_sw, 3, 0, 5));
        append_instr(1, itype_word(op_lw, 4, 0, 4));
        append_instr(1, rtype_word(alu_sub, 5, 1, 4, 0));
        append_instr(1, itype_word(op_sw, 5, 0, 6));
        close_program(1);
        preload_word(1, 103, 32'h1234_5678);
        preload_word(1, 4, 32'h8000_0010);
        expect_store(1, 5, 32'h1234_5678 + 32'd100);
        expect_store(1, 6, 32'd100 - 32'h8000_0010);
        // bne and blt, taken and not taken
        append_instr(2, itype_word(op_addi, 1, 0, 3));
        append_instr(2, itype_word(op_addi, 2, 0, 5));
        append_instr(2, itype_word(op_bne, 1, 2, 2));       // 3 != 5, to 5
        append_instr(2, itype_word(op_sw, 1, 0, 10));
        append_instr(2, itype_word(op_sw, 2, 0, 11));
        append_instr(2, itype_word(op_blt, 2, 1, 1));       // 5 < 3 fails
        append_instr(2, itype_word(op_sw, 1, 0, 12));
        append_instr(2, itype_word(op_blt, 1, 2, 2));       // 3 < 5, to 10
        append_instr(2, itype_word(op_sw, 1, 0, 13));
        append_instr(2, itype_word(op_sw, 2, 0, 14));
        append_instr(2, itype_word(op_bne, 1, 1, 1));       // Equal, falls through
        append_instr(2, itype_word(op_sw, 2, 0, 15));
        append_instr(2, itype_word(op_addi, 3, 0, -4));
        append_instr(2, itype_word(op_blt, 3, 1, 1));       // Signed -4 < 3
        append_instr(2, itype_word(op_sw, 3, 0, 16));
        append_instr(2, itype_word(op_sw, 3, 0, 17));
        close_program(2);
        expect_store(2, 12, 32'd3);
        expect_store(2, 15, 32'd5);
        expect_store(2, 17, 32'hffff_fffc);
        // j, jal and jr back to the link
        append_instr(3, itype_word(op_addi, 1, 0, 7));
        append_instr(3, jump_word(op_j, 4));
        append_instr(3, itype_word(op_sw, 1, 0, 20));
        append_instr(3, itype_word(op_sw, 1, 0, 21));
        append_instr(3, jump_word(op_jal, 8));              // r31 gets 5
        append_instr(3, itype_word(op_sw, 1, 0, 22));
        append_instr(3, itype_word(op_sw, 31, 0, 23));
        append_instr(3, jump_word(op_j, 12));
        append_instr(3, itype_word(op_sw, 31, 0, 24));
        append_instr(3, itype_word(op_jr, 31, 0, 0));
        append_instr(3, itype_word(op_sw, 1, 0, 25));
        append_instr(3, itype_word(op_sw, 1, 0, 26));
        close_program(3);
        expect_store(3, 24, 32'd5);
        expect_store(3, 22, 32'd7);
        expect_store(3, 23, 32'd5);
        // Store of a just-loaded register, r0 stays zero
        append_instr(4, itype_word(op_addi, 1, 0, 40));
        append_instr(4, itype_word(op_lw, 2, 1, 0));
        append_instr(4, itype_word(op_sw, 2, 1, 1));
        append_instr(4, itype_word(op_addi, 0, 0, 9));
        append_instr(4, rtype_word(alu_add, 3, 0, 0, 0));  // r0 one behind, MX slot
        append_instr(4, itype_word(op_sw, 0, 1, 3));       // r0 two behind, WX slot
        append_instr(4, itype_word(op_sw, 3, 1, 2));
        close_program(4);
        preload_word(4, 40, 32'hcafe_f00d);
        expect_store(4, 41, 32'hcafe_f00d);
        expect_store(4, 43, 32'd0);
        expect_store(4, 42, 32'd0);
        // No stores before the end marker
        append_instr(5, itype_word(op_addi, 1, 0, 1));
        append_instr(5, itype_word(op_addi, 2, 1, 2));
        append_instr(5, itype_word(op_lw, 3, 0, 0));
        close_program(5);
    endtask

    task automatic check_word(input string name, input logic [xlen-1:0] got,
                              input logic [xlen-1:0] expected);
        checks++;
        if (got !== expected) begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic check_count(input int got, input int expected);
        checks++;
        if (got != expected) begin
            $display("Error at %0t: store count is %0d, expected %0d", $time, got, expected);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        checks++;
        if (got !== expected) begin
            $display("Error at %0t: %s is %b, expected %b", $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic check_pc(input logic [11:0] got, input logic [11:0] expected);
        checks++;
        if (got !== expected) begin
            $display("Error at %0t: address_imem is %h, expected %h", $time, got, expected);
            errors++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("Failure at %0t: %s", $time, what);
        errors++;
    endtask

    task automatic load_memories(input int t);
        for (int a = 0; a < 4096; a++) begin
            imem[a] = '0;                                    // All-zero word is a nop
        end
        for (int a = 0; a < 1024; a++) begin
            dmem[a] = 32'hd00d_0000 ^ 32'(a * 7919);
        end
        for (int k = 0; k < prog_len[t]; k++) begin
            imem[k] = prog[t][k];
        end
        for (int k = 0; k < data_cnt[t]; k++) begin
            dmem[data_addr[t][k]] = data_val[t][k];
        end
    endtask

    task automatic run_test(input int t);
        int   n;
        int   errors_before;
        logic done;
        errors_before = errors;
        n             = 0;
        done          = 1'b0;
        @(posedge clock);
        #1 rst_n = 1'b0;
        load_memories(t);
        for (int k = 0; k < 3; k++) begin
            @(posedge clock);
            #1;
            if (k == 2) begin
                rst_n = 1'b1;
            end
            check_flag("wren", wren, 1'b0);
            check_pc(address_imem, '0);                      // PC sits at word 0 in reset
        end
        while (!done) begin
            @(negedge clock);                                // Mid-cycle, outputs settled
            if (wren === 1'b1) begin
                if (address_dmem == xlen'(end_addr)) begin
                    done = 1'b1;
                end else begin
                    if (n < exp_cnt[t]) begin
                        check_word("address_dmem", address_dmem, exp_addr[t][n]);
                        check_word("data", data, exp_data[t][n]);
                    end
                    n++;
                    if (address_dmem < 32'd1024) begin
                        dmem[address_dmem[9:0]] = data;      // Seen by reads next cycle
                    end else begin
                        report_failure("store outside data memory");
                    end
                end
            end else if (wren !== 1'b0) begin
                report_failure("wren is unknown");
            end
        end
        check_count(n, exp_cnt[t]);
        $display("Test %0d done: %0d stores, %s", t + 1, n,
                 (errors == errors_before) ? "clean" : "mismatch");
    endtask

    initial begin
        build_table();
        total_len = 0;
        for (int t = 0; t < num_tests; t++) begin
            total_len += prog_len[t];
        end
        cycle_limit = 4 * total_len + 50;
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        $display("%0d tests, %0d checks, %0d errors", num_tests, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu import pipe5_pkg::*; (
    input  logic [xlen-1:0] operand_a,
    input  logic [xlen-1:0] operand_b,
    input  logic [4:0]      alu_op,
    input  logic [4:0]      shamt,
    output logic [xlen-1:0] result,
    output logic            not_equal,
    output logic            less_than
);

    logic [xlen-1:0] sum;
    logic [xlen-1:0] diff;
    logic            diff_ovf;

    assign sum  = operand_a + operand_b;
    assign diff = operand_a - operand_b;

    // Signs differ and the difference takes the sign of b
    assign diff_ovf = (operand_a[xlen-1] ^ operand_b[xlen-1])
                    & (diff[xlen-1] ^ operand_a[xlen-1]);

    assign not_equal = |diff;
    assign less_than = diff[xlen-1] ^ diff_ovf;    // Signed a < b

    always_comb begin
        case (alu_op)
            alu_add: result = sum;
            alu_sub: result = diff;
            alu_and: result = operand_a & operand_b;
            alu_or:  result = operand_a | operand_b;
            alu_sll: result = operand_a << shamt;
            alu_sra: result = $signed(operand_a) >>> shamt;
            default: result = sum;                 // Unused codes add
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage import pipe5_pkg::*; #(
    parameter int pc_w = 12
) (
    input  logic             clock,
    input  logic             rst_n,
    input  logic [pc_w-1:0]  fd_pc,
    input  instr_t           fd_instr,
    output logic [reg_w-1:0] read_a,
    output logic [reg_w-1:0] read_b,
    input  logic [xlen-1:0]  data_a,
    input  logic [xlen-1:0]  data_b,
    input  logic             branch_taken,
    input  logic [reg_w-1:0] mem_rd,
    input  logic             mem_writes,
    input  logic             dx_rd_is_load,   // Load with a real rd sits in execute
    output logic             stall,
    output logic             jr_redirect,
    output logic [pc_w-1:0]  jr_target,
    output logic [pc_w-1:0]  dx_pc,
    output instr_t           dx_instr,
    output logic [xlen-1:0]  dx_a,
    output logic [xlen-1:0]  dx_b
);

    logic [4:0] opcode;
    logic       is_rtype;
    logic       is_jr;
    logic       uses_a;      // rs is a source
    logic       uses_b;      // rt or rd is an ALU/branch source
    logic       load_use;
    logic       jr_wait;

    assign opcode   = fd_instr.r.opcode;
    assign is_rtype = opcode == op_rtype;
    assign is_jr    = opcode == op_jr;

    // Port A is always rs; port B is rt for R-type, else rd (sw data, branch, jr)
    assign read_a = fd_instr.r.rs;
    assign read_b = is_rtype ? fd_instr.r.rt : fd_instr.i.rd;

    assign uses_a = is_rtype || opcode == op_addi || opcode == op_lw
                  || opcode == op_sw || opcode == op_bne || opcode == op_blt;
    // sw data is left out, the memory stage bypasses it from the load
    assign uses_b = is_rtype || opcode == op_bne || opcode == op_blt;

    assign load_use = dx_rd_is_load
                    && ((uses_a && dx_instr.i.rd == read_a)
                        || (uses_b && dx_instr.i.rd == read_b));

    // jr reads the register file directly, so wait out any in-flight writer
    assign jr_wait = is_jr
                   && ((mem_writes && mem_rd == read_b)
                       || (dest_reg(dx_instr) != reg_zero && dest_reg(dx_instr) == read_b));

    assign stall       = load_use || jr_wait;
    assign jr_redirect = is_jr && !jr_wait;
    assign jr_target   = data_b[pc_w-1:0];    // Write-through covers writeback

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            dx_instr <= '0;
        end else if (branch_taken || stall) begin
            dx_instr <= '0;                      // Bubble into execute
        end else begin
            dx_instr <= fd_instr;
        end
    end

    always_ff @(posedge clock) begin
        dx_pc <= fd_pc;
        dx_a  <= data_a;
        dx_b  <= data_b;
    end

endmodule

`default_nettype wire

//--- verilog/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage import pipe5_pkg::*; #(
    parameter int pc_w = 12
) (
    input  logic             clock,
    input  logic             rst_n,
    input  logic [pc_w-1:0]  dx_pc,
    input  instr_t           dx_instr,
    input  logic [xlen-1:0]  dx_a,
    input  logic [xlen-1:0]  dx_b,
    input  logic [reg_w-1:0] mem_rd,
    input  logic             mem_writes,
    input  logic [xlen-1:0]  mem_result,
    input  logic             wb_en,
    input  logic [reg_w-1:0] wb_reg,
    input  logic [xlen-1:0]  wb_data,
    output logic             branch_taken,
    output logic [pc_w-1:0]  branch_target,
    output logic [pc_w-1:0]  xm_pc,
    output instr_t           xm_instr,
    output logic [xlen-1:0]  xm_result,
    output logic [xlen-1:0]  xm_store
);

    logic [4:0]       opcode;
    logic             is_rtype;
    logic             is_bne;
    logic             is_blt;
    logic [reg_w-1:0] src_b;
    logic [xlen-1:0]  op_a;        // rs after bypass
    logic [xlen-1:0]  op_b;        // rt or rd after bypass
    logic [xlen-1:0]  imm_ext;
    logic [xlen-1:0]  alu_a;
    logic [xlen-1:0]  alu_b;
    logic [4:0]       alu_sel;
    logic [xlen-1:0]  alu_out;
    logic             not_equal;
    logic             less_than;

    assign opcode   = dx_instr.r.opcode;
    assign is_rtype = opcode == op_rtype;
    assign is_bne   = opcode == op_bne;
    assign is_blt   = opcode == op_blt;
    assign src_b    = is_rtype ? dx_instr.r.rt : dx_instr.i.rd;

    // Newest value first; r0 never shows up as a writer
    function automatic logic [xlen-1:0] bypass(input logic [reg_w-1:0] src,
                                               input logic [xlen-1:0]  reg_val);
        if (mem_writes && mem_rd == src) begin
            return mem_result;              // MX
        end
        if (wb_en && wb_reg == src) begin
            return wb_data;                 // WX
        end
        return reg_val;
    endfunction

    always_comb begin
        op_a = bypass(dx_instr.r.rs, dx_a);
        op_b = bypass(src_b, dx_b);
    end

    assign imm_ext = {{(xlen-17){dx_instr.i.imm[16]}}, dx_instr.i.imm};

    // Operand routing per format
    always_comb begin
        alu_a   = op_a;
        alu_b   = imm_ext;                  // addi, lw, sw
        alu_sel = alu_add;
        if (is_rtype) begin
            alu_b   = op_b;
            alu_sel = dx_instr.r.alu_op;
        end else if (is_bne || is_blt) begin
            alu_a   = op_b;                 // rd - rs, so less_than means rd < rs
            alu_b   = op_a;
            alu_sel = alu_sub;
        end
    end

    alu i_alu (
        .operand_a (alu_a),
        .operand_b (alu_b),
        .alu_op    (alu_sel),
        .shamt     (dx_instr.r.shamt),
        .result    (alu_out),
        .not_equal (not_equal),
        .less_than (less_than)
    );

    assign branch_taken  = (is_bne && not_equal) || (is_blt && less_than);
    assign branch_target = dx_pc + 1'b1 + imm_ext[pc_w-1:0];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            xm_instr <= '0;
        end else begin
            xm_instr <= dx_instr;           // Branch itself moves on
        end
    end

    always_ff @(posedge clock) begin
        xm_pc     <= dx_pc;
        xm_result <= alu_out;
        xm_store  <= op_b;                  // sw data from rd
    end

endmodule

`default_nettype wire

//--- verilog/fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_stage import pipe5_pkg::*; #(
    parameter int pc_w = 12
) (
    input  logic            clock,
    input  logic            rst_n,
    input  instr_t          q_imem,
    input  logic            stall,           // Hold PC and F/D
    input  logic            jr_redirect,     // jr leaving decode
    input  logic [pc_w-1:0] jr_target,
    input  logic            branch_taken,    // Resolved in execute
    input  logic [pc_w-1:0] branch_target,
    output logic [pc_w-1:0] address_imem,
    output logic [pc_w-1:0] fd_pc,
    output instr_t          fd_instr
);

    logic [pc_w-1:0] pc;
    logic [pc_w-1:0] next_pc;
    logic            fetch_jump;    // j or jal coming out of imem
    logic            flush;         // Fetched word is on a wrong path

    assign address_imem = pc;

    // Predecode so j/jal redirect with no bubble
    assign fetch_jump = (q_imem.ji.opcode == op_j) || (q_imem.ji.opcode == op_jal);
    assign flush      = branch_taken || jr_redirect;

    // Oldest redirect wins
    always_comb begin
        if (branch_taken) begin
            next_pc = branch_target;
        end else if (jr_redirect) begin
            next_pc = jr_target;
        end else if (fetch_jump) begin
            next_pc = q_imem.ji.target[pc_w-1:0];
        end else begin
            next_pc = pc + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pc       <= '0;
            fd_instr <= '0;                // All-zero word is a nop
        end else begin
            if (flush || !stall) begin
                pc <= next_pc;             // A redirect overrides a stall
            end
            if (flush) begin
                fd_instr <= '0;            // Squash wrong-path word
            end else if (!stall) begin
                fd_instr <= q_imem;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            fd_pc <= pc;
        end
    end

endmodule

`default_nettype wire

//--- verilog/mem_wb_stage.sv
`timescale 1ns/1ns
`default_nettype none

module mem_wb_stage import pipe5_pkg::*; #(
    parameter int pc_w = 12
) (
    input  logic             clock,
    input  logic             rst_n,
    input  logic [pc_w-1:0]  xm_pc,
    input  instr_t           xm_instr,
    input  logic [xlen-1:0]  xm_result,
    input  logic [xlen-1:0]  xm_store,
    input  instr_t           dx_instr,       // Only for the load-use check
    output logic [xlen-1:0]  address_dmem,
    output logic [xlen-1:0]  data,
    output logic             wren,
    input  logic [xlen-1:0]  q_dmem,
    output logic [reg_w-1:0] mem_rd,
    output logic             mem_writes,
    output logic [xlen-1:0]  mem_result,
    output logic             dx_rd_is_load,
    output logic             wb_en,
    output logic [reg_w-1:0] wb_reg,
    output logic [xlen-1:0]  wb_data
);

    instr_t          mw_instr;
    logic [pc_w-1:0] mw_pc;
    logic [xlen-1:0] mw_result;
    logic [xlen-1:0] mw_load;
    logic            store_bypass;

    // Return address for jal
    function automatic logic [xlen-1:0] link_value(input logic [pc_w-1:0] pc);
        return xlen'(pc) + 1'b1;
    endfunction

    assign dx_rd_is_load = (dx_instr.i.opcode == op_lw) && (dx_instr.i.rd != reg_zero);

    // Memory stage as a bypass source
    assign mem_rd     = dest_reg(xm_instr);
    assign mem_writes = mem_rd != reg_zero;
    assign mem_result = (xm_instr.r.opcode == op_jal) ? link_value(xm_pc) : xm_result;

    assign address_dmem = xm_result;
    assign wren         = xm_instr.i.opcode == op_sw;

    // Load one ahead wrote the sw data register
    assign store_bypass = wren && (mw_instr.i.opcode == op_lw)
                        && wb_en && (wb_reg == xm_instr.i.rd);
    assign data = store_bypass ? wb_data : xm_store;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            mw_instr <= '0;
        end else begin
            mw_instr <= xm_instr;
        end
    end

    always_ff @(posedge clock) begin
        mw_pc     <= xm_pc;
        mw_result <= xm_result;
        mw_load   <= q_dmem;
    end

    // Writeback select
    assign wb_reg = dest_reg(mw_instr);
    assign wb_en  = wb_reg != reg_zero;       // r0 writes never leave here

    always_comb begin
        case (mw_instr.r.opcode)
            op_lw:   wb_data = mw_load;
            op_jal:  wb_data = link_value(mw_pc);
            default: wb_data = mw_result;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/pipe5_cpu.sv
`timescale 1ns/1ns
`default_nettype none

module pipe5_cpu import pipe5_pkg::*; #(
    parameter int pc_w = 12           // Word-addressed PC width, 8 to 27
) (
    input  logic            clock,
    input  logic            rst_n,
    output logic [pc_w-1:0] address_imem,
    input  instr_t          q_imem,
    output logic [xlen-1:0] address_dmem,
    output logic [xlen-1:0] data,
    output logic            wren,
    input  logic [xlen-1:0] q_dmem
);

    // Fetch to decode
    logic [pc_w-1:0]  fd_pc;
    instr_t           fd_instr;
    logic             stall;
    logic             jr_redirect;
    logic [pc_w-1:0]  jr_target;

    // Decode to register file and execute
    logic [reg_w-1:0] read_a;
    logic [reg_w-1:0] read_b;
    logic [xlen-1:0]  data_a;
    logic [xlen-1:0]  data_b;
    logic [pc_w-1:0]  dx_pc;
    instr_t           dx_instr;
    logic [xlen-1:0]  dx_a;
    logic [xlen-1:0]  dx_b;

    // Branch resolution, seen by fetch and decode
    logic             branch_taken;
    logic [pc_w-1:0]  branch_target;

    // Execute to memory
    logic [pc_w-1:0]  xm_pc;
    instr_t           xm_instr;
    logic [xlen-1:0]  xm_result;
    logic [xlen-1:0]  xm_store;

    // Hazard and bypass sources from the back end
    logic [reg_w-1:0] mem_rd;
    logic             mem_writes;
    logic [xlen-1:0]  mem_result;
    logic             dx_rd_is_load;
    logic             wb_en;
    logic [reg_w-1:0] wb_reg;
    logic [xlen-1:0]  wb_data;

    // Port names match the wires above, so all stages connect by name
    fetch_stage   #(.pc_w(pc_w)) i_fetch_stage   (.*);
    decode_stage  #(.pc_w(pc_w)) i_decode_stage  (.*);
    regfile                      i_regfile       (.*);
    execute_stage #(.pc_w(pc_w)) i_execute_stage (.*);
    mem_wb_stage  #(.pc_w(pc_w)) i_mem_wb_stage  (.*);

endmodule

`default_nettype wire

//--- verilog/pipe5_pkg.sv
`default_nettype none

package pipe5_pkg;

    localparam int xlen  = 32;    // Data word width
    localparam int reg_w = 5;     // Register number width

    // Opcodes
    localparam logic [4:0] op_rtype = 5'b00000;
    localparam logic [4:0] op_j     = 5'b00001;
    localparam logic [4:0] op_bne   = 5'b00010;
    localparam logic [4:0] op_jal   = 5'b00011;
    localparam logic [4:0] op_jr    = 5'b00100;
    localparam logic [4:0] op_addi  = 5'b00101;
    localparam logic [4:0] op_blt   = 5'b00110;
    localparam logic [4:0] op_sw    = 5'b00111;
    localparam logic [4:0] op_lw    = 5'b01000;

    // ALU codes, also the R-type alu_op field
    localparam logic [4:0] alu_add = 5'b00000;
    localparam logic [4:0] alu_sub = 5'b00001;
    localparam logic [4:0] alu_and = 5'b00010;
    localparam logic [4:0] alu_or  = 5'b00011;
    localparam logic [4:0] alu_sll = 5'b00100;
    localparam logic [4:0] alu_sra = 5'b00101;

    localparam logic [reg_w-1:0] reg_zero = 5'd0;
    localparam logic [reg_w-1:0] reg_ra   = 5'd31;    // Link register for jal

    // One instruction word, read as R, I or JI format
    typedef union packed {
        struct packed {
            logic [4:0]       opcode;
            logic [reg_w-1:0] rd;
            logic [reg_w-1:0] rs;
            logic [reg_w-1:0] rt;
            logic [4:0]       shamt;
            logic [4:0]       alu_op;
            logic [1:0]       pad;
        } r;
        struct packed {
            logic [4:0]       opcode;
            logic [reg_w-1:0] rd;
            logic [reg_w-1:0] rs;
            logic [16:0]      imm;     // Signed
        } i;
        struct packed {
            logic [4:0]  opcode;
            logic [26:0] target;       // Absolute word address
        } ji;
    } instr_t;

    // Register written by an instruction, reg_zero when it writes none
    function automatic logic [reg_w-1:0] dest_reg(input instr_t instr);
        case (instr.r.opcode)
            op_rtype, op_addi, op_lw: return instr.r.rd;
            op_jal:                   return reg_ra;
            default:                  return reg_zero;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- verilog/regfile.sv
`timescale 1ns/1ns
`default_nettype none

module regfile import pipe5_pkg::*; (
    input  logic             clock,
    input  logic             rst_n,
    input  logic [reg_w-1:0] read_a,
    input  logic [reg_w-1:0] read_b,
    output logic [xlen-1:0]  data_a,
    output logic [xlen-1:0]  data_b,
    input  logic             wb_en,
    input  logic [reg_w-1:0] wb_reg,
    input  logic [xlen-1:0]  wb_data
);

    logic [xlen-1:0] regs [32];

    // r0 stays zero, same-cycle write is forwarded
    function automatic logic [xlen-1:0] read_port(input logic [reg_w-1:0] addr);
        if (addr == reg_zero) begin
            return '0;
        end
        if (wb_en && wb_reg == addr) begin
            return wb_data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        data_a = read_port(read_a);
        data_b = read_port(read_b);
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;           // Known state for each run
            end
        end else if (wb_en && wb_reg != reg_zero) begin
            regs[wb_reg] <= wb_data;
        end
    end

endmodule

`default_nettype wire
